/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module la_tb

sim:
	verilator --binary --timing --assert -f build.f --top-module la_tb -o la_sim
	./obj_dir/la_sim +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "Simulation passed" sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
verilog/la_pkg.sv
verilog/la_regs.sv
verilog/la_trigger.sv
verilog/la_probe_select.sv
verilog/la_capture.sv
verilog/la_top.sv
verif/la_assertions.sv
verif/la_tb.sv

/* verif/la_assertions.sv */
module la_assertions (
   input logic                                observer_clk,
   input logic                                reset,
   input la_pkg::la_apb_req_t                 apb,
   input logic [la_pkg::la_data_w-1:0]        prdata,
   input la_pkg::la_probes_t                  probes,
   input logic                                fifo_wr,
   input la_pkg::la_fifo_word_t               fifo_wr_data,
   input logic                                capture_active
);
   timeunit 1ns;
   timeprecision 1ps;

   logic        error_seen = 1'b0;   // Polled by the testbench
   logic [2:0]  group_sh;
   logic [5:0]  trig_sh;
   logic [15:0] depth_sh;
   logic [15:0] down_sh;
   logic        manual_sh;
   logic        arm_pend;            // ARM written, capture not yet started
   logic        cap_q;
   logic [1:0]  cap_age;
   logic [31:0] wr_cnt;
   logic [31:0] gap;                 // Cycles since the last FIFO write
   logic [31:0] exp_rd;
   logic        known;
   logic        wr_acc;
   logic        rd_acc;

   assign wr_acc = apb.psel & apb.penable & apb.pwrite;
   assign rd_acc = apb.psel & apb.penable & ~apb.pwrite;

   always_comb begin
      exp_rd = '0;
      known  = 1'b1;
      case (apb.paddr)
         la_pkg::la_addr_group:  exp_rd[2:0] = group_sh;
         la_pkg::la_addr_trig:   exp_rd[5:0] = trig_sh;
         la_pkg::la_addr_depth:  exp_rd[15:0] = depth_sh;
         la_pkg::la_addr_down:   exp_rd[15:0] = down_sh;
         la_pkg::la_addr_manual: exp_rd[0] = manual_sh;
         default:                known = 1'b0;
      endcase
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         group_sh  <= '0;
         trig_sh   <= '0;
         depth_sh  <= 16'd16;
         down_sh   <= '0;
         manual_sh <= 1'b0;
         arm_pend  <= 1'b0;
         cap_q     <= 1'b0;
      end else begin
         cap_q <= capture_active;
         if (capture_active & ~cap_q)
            arm_pend <= 1'b0;
         if (wr_acc) begin
            case (apb.paddr)
               la_pkg::la_addr_group:  group_sh <= apb.pwdata[2:0];
               la_pkg::la_addr_trig:   trig_sh <= apb.pwdata[5:0];
               la_pkg::la_addr_depth:  depth_sh <= apb.pwdata[15:0];
               la_pkg::la_addr_down:   down_sh <= apb.pwdata[15:0];
               la_pkg::la_addr_manual: manual_sh <= apb.pwdata[0];
               la_pkg::la_addr_arm:    arm_pend <= apb.pwdata[0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset || !capture_active) begin
         wr_cnt  <= '0;
         gap     <= '1;
         cap_age <= '0;
      end else begin
         if (cap_age != 2'd3)
            cap_age <= cap_age + 1'b1;
         if (fifo_wr) begin
            wr_cnt <= wr_cnt + 1;
            gap    <= 32'd1;
         end else if (gap != '1) begin
            gap <= gap + 1;
         end
      end
   end

   // Each userio bit appears twice in its probe pair
   function automatic logic userio_pairs_ok(la_pkg::la_fifo_word_t data, logic [7:0] uio);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < 8; i++)
         if (data[i] != {2{uio[i]}})
            ok = 1'b0;
      return ok;
   endfunction

   readback_check: assert property (@(posedge observer_clk) disable iff (reset)
      rd_acc && known |-> prdata == exp_rd)
   else begin
      $error("Fail prdata at %h got %h expected %h", apb.paddr, prdata, exp_rd);
      error_seen = 1'b1;
   end

   write_count_check: assert property (@(posedge observer_clk) disable iff (reset)
      $fell(capture_active) |-> wr_cnt == 32'(depth_sh / 2))
   else begin
      $error("Fail fifo_wr count got %h expected %h", wr_cnt, depth_sh / 2);
      error_seen = 1'b1;
   end

   spacing_check: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |-> capture_active && gap >= 32'(down_sh) * 2 + 2)
   else begin
      $error("Fail fifo_wr gap %h capture_active %h", gap, capture_active);
      error_seen = 1'b1;
   end

   pattern_check: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr && group_sh >= 3'd3 |-> fifo_wr_data == 18'h33333)
   else begin
      $error("Fail fifo_wr_data got %h expected %h", fifo_wr_data, 18'h33333);
      error_seen = 1'b1;
   end

   userio_check: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr && group_sh == 3'd1 |-> userio_pairs_ok(fifo_wr_data, probes.userio))
   else begin
      $error("Fail fifo_wr_data got %h userio %h", fifo_wr_data, probes.userio);
      error_seen = 1'b1;
   end

   arm_check: assert property (@(posedge observer_clk) disable iff (reset)
      $rose(capture_active) |-> arm_pend)
   else begin
      $error("Capture started without an ARM write");
      error_seen = 1'b1;
   end

   status_check: assert property (@(posedge observer_clk) disable iff (reset)
      rd_acc && apb.paddr == la_pkg::la_addr_status && cap_age >= 2'd2
      |-> prdata[2:1] == 2'b01)
   else begin
      $error("Fail prdata status got %h expected %h", prdata[2:0], 3'h2);
      error_seen = 1'b1;
   end

endmodule

bind la_top la_assertions la_assertions_inst (.*);

/* verif/la_tb.sv */
module la_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_rand = 6;

   logic                         observer_clk = 1'b0;
   logic                         reset;
   la_pkg::la_apb_req_t          apb;
   logic [la_pkg::la_data_w-1:0] prdata;
   la_pkg::la_probes_t           probes;
   logic                         fifo_wr;
   la_pkg::la_fifo_word_t        fifo_wr_data;
   logic                         capture_active;
   int                           cycles = 0;
   int                           limit = 0;
   int                           rand_depth[n_rand];
   int                           rand_down[n_rand];

   la_top la_top_inst (.*);

   always #20 observer_clk = ~observer_clk;

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   always @(posedge observer_clk) begin
      cycles = cycles + 1;
      if (limit != 0 && cycles > limit)
         stop_with_failure("Timeout, the tests did not finish in time");
   end

   always @(negedge observer_clk)
      if (la_top_inst.la_assertions_inst.error_seen)
         stop_with_failure("An assertion check failed");

   function automatic int test_cost(int down, int depth);
      return (down + 1) * (depth + 2) + 200;
   endfunction

   // Setup phase, access phase, then idle
   task automatic apb_access(logic write, logic [7:0] addr, logic [31:0] data);
      @(negedge observer_clk);
      apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
      @(negedge observer_clk);
      apb.penable = 1'b1;
      @(negedge observer_clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apb_write(logic [7:0] addr, logic [31:0] data);
      apb_access(1'b1, addr, data);
   endtask

   task automatic apb_read(logic [7:0] addr);
      apb_access(1'b0, addr, '0);
   endtask

   task automatic pulse_manual();
      apb_write(la_pkg::la_addr_manual, 32'd1);
      apb_write(la_pkg::la_addr_manual, 32'd0);
   endtask

   task automatic fire_trigger(logic [5:0] trig);
      case (trig)
         6'h29:   probes.io[1] = 1'b0;       // Inverted io[1] rises
         6'h0A:   probes.userio[2] = 1'b1;
         default: pulse_manual();
      endcase
   endtask

   task automatic run_capture(logic [2:0] group, int depth, int down, logic [5:0] trig);
      probes.io[1]     = 1'b1;               // Idle source levels
      probes.userio[2] = 1'b0;
      apb_write(la_pkg::la_addr_group, 32'(group));
      apb_write(la_pkg::la_addr_depth, 32'(depth));
      apb_write(la_pkg::la_addr_down, 32'(down));
      apb_write(la_pkg::la_addr_trig, 32'(trig));
      apb_read(la_pkg::la_addr_depth);
      repeat (4) @(negedge observer_clk);
      apb_write(la_pkg::la_addr_arm, 32'd1);
      fire_trigger(trig);
      while (!capture_active)
         @(negedge observer_clk);
      repeat (3) @(negedge observer_clk);
      apb_read(la_pkg::la_addr_status);
      while (capture_active)
         @(negedge observer_clk);
      repeat (4) @(negedge observer_clk);
   endtask

   initial begin
      void'($urandom(32'h8e57));
      reset         = 1'b1;
      apb           = '0;
      probes        = '0;
      probes.io[1]  = 1'b1;
      probes.userio = 8'($urandom);
      probes.debug  = 9'($urandom);
      limit = 3 * 200 + test_cost(0, 10) + test_cost(2, 12) + 2 * test_cost(1, 8);
      for (int i = 0; i < n_rand; i++) begin
         rand_depth[i] = 2 + int'($urandom % 39);
         rand_down[i]  = int'($urandom % 4);
         limit         = limit + test_cost(rand_down[i], rand_depth[i]);
      end
      repeat (2) @(negedge observer_clk);
      reset = 1'b0;

      // Readback of random values
      apb_write(la_pkg::la_addr_group, $urandom);
      apb_write(la_pkg::la_addr_trig, $urandom);
      apb_write(la_pkg::la_addr_depth, $urandom);
      apb_write(la_pkg::la_addr_down, $urandom);
      apb_write(la_pkg::la_addr_manual, $urandom);
      apb_read(la_pkg::la_addr_group);
      apb_read(la_pkg::la_addr_trig);
      apb_read(la_pkg::la_addr_depth);
      apb_read(la_pkg::la_addr_down);
      apb_read(la_pkg::la_addr_manual);
      apb_write(la_pkg::la_addr_manual, 32'd0);

      // Triggers without ARM
      apb_write(la_pkg::la_addr_trig, 32'h29);
      repeat (4) @(negedge observer_clk);
      probes.io[1] = 1'b0;
      repeat (10) @(negedge observer_clk);
      pulse_manual();
      repeat (10) @(negedge observer_clk);

      run_capture(3'd3, 10, 0, 6'h10);
      run_capture(3'd1, 12, 2, 6'h29);
      run_capture(3'd2, 8, 1, 6'h0A);
      run_capture(3'd0, 8, 1, 6'h10);
      for (int i = 0; i < n_rand; i++)
         run_capture(3'(($urandom % 2) * 2), rand_depth[i], rand_down[i], 6'h10);

      repeat (2) @(negedge observer_clk);
      if (la_top_inst.la_assertions_inst.error_seen) begin
         stop_with_failure("An assertion check failed");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

/* verilog/la_capture.sv */
module la_capture (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic                           trig_go,
   input  logic                           arm_req,
   input  logic [la_pkg::la_depth_w-1:0]  depth,
   input  logic [la_pkg::la_depth_w-1:0]  downsample,
   input  logic [la_pkg::la_probe_n-1:0]  samples,
   output logic                           armed,
   output logic                           capturing,
   output logic                           fifo_wr,
   output la_pkg::la_fifo_word_t          fifo_wr_data
);

   logic                          capture_go;
   logic                          sample_tick;
   logic                          toggle;
   logic [la_pkg::la_depth_w-1:0] ds_cnt;
   logic [la_pkg::la_depth_w-1:0] sample_cnt;
   la_pkg::la_fifo_word_t         history;

   // No restart while a capture is running
   assign capture_go = trig_go & armed & ~capturing;

   // One sample every downsample+1 cycles, stops after depth samples
   assign sample_tick = capturing && (sample_cnt != depth) && (ds_cnt == downsample);

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         armed      <= 1'b0;
         capturing  <= 1'b0;
         toggle     <= 1'b0;
         fifo_wr    <= 1'b0;
         ds_cnt     <= '0;
         sample_cnt <= '0;
      end else begin
         fifo_wr <= 1'b0;
         if (capture_go) begin
            armed      <= 1'b0;
            capturing  <= 1'b1;
            toggle     <= 1'b0;
            ds_cnt     <= '0;
            sample_cnt <= '0;
         end else begin
            if (arm_req)
               armed <= 1'b1;
            ds_cnt <= (ds_cnt == downsample) ? '0 : ds_cnt + 1'b1;
            if (sample_tick) begin
               sample_cnt <= sample_cnt + 1'b1;
               toggle     <= ~toggle;
               fifo_wr    <= toggle;   // Every second sample completes a pair
            end
            // Held one extra cycle so the last write lands inside the window
            if (capturing && (sample_cnt == depth))
               capturing <= 1'b0;
         end
      end
   end

   always_ff @(posedge observer_clk) begin
      if (sample_tick) begin
         for (int i = 0; i < la_pkg::la_probe_n; i++)
            history[i] <= {history[i][0], samples[i]};
      end
   end

   assign fifo_wr_data = history;

endmodule

/* verilog/la_pkg.sv */
package la_pkg;

   // Bus and datapath widths
   localparam int la_addr_w  = 8;
   localparam int la_data_w  = 32;
   localparam int la_depth_w = 16;
   localparam int la_probe_n = 9;

   // Register map
   localparam logic [la_addr_w-1:0] la_addr_group  = 8'h04;
   localparam logic [la_addr_w-1:0] la_addr_status = 8'h08;
   localparam logic [la_addr_w-1:0] la_addr_trig   = 8'h0C;
   localparam logic [la_addr_w-1:0] la_addr_depth  = 8'h10;
   localparam logic [la_addr_w-1:0] la_addr_down   = 8'h14;
   localparam logic [la_addr_w-1:0] la_addr_arm    = 8'h18;
   localparam logic [la_addr_w-1:0] la_addr_manual = 8'h1C;

   // Capture groups, values 3 to 7 all give the test pattern
   typedef enum logic [2:0] {
      la_group_port    = 3'd0,
      la_group_userio  = 3'd1,
      la_group_debug   = 3'd2,
      la_group_pattern = 3'd3
   } la_group_e;

   typedef logic [5:0] la_trig_sel_t;

   typedef struct packed {
      logic                 psel;
      logic                 penable;
      logic                 pwrite;
      logic [la_addr_w-1:0] paddr;
      logic [la_data_w-1:0] pwdata;
   } la_apb_req_t;

   typedef struct packed {
      logic [3:0] io;
      logic [7:0] userio;
      logic       userio_clk;
      logic [1:0] hs;
      logic       aux_mcx;
      logic       trig_mcx;
      logic       adc_sample_clk;
      logic [8:0] debug;
   } la_probes_t;

   typedef struct packed {
      la_group_e             group;
      la_trig_sel_t          trig_sel;
      logic [la_depth_w-1:0] depth;
      logic [la_depth_w-1:0] downsample;
      logic                  manual;
   } la_config_t;

   // One bit pair per probe, older sample in the upper bit
   typedef logic [la_probe_n-1:0][1:0] la_fifo_word_t;

endpackage

/* verilog/la_probe_select.sv */
module la_probe_select (
   input  logic                          observer_clk,
   input  la_pkg::la_probes_t            probes,
   input  la_pkg::la_group_e             group,
   output logic [la_pkg::la_probe_n-1:0] samples
);

   // First register on the asynchronous probe pins
   always_ff @(posedge observer_clk) begin
      case (group)
         la_pkg::la_group_port: begin
            samples[3:0] <= probes.io;
            samples[5:4] <= probes.hs;
            samples[6]   <= probes.aux_mcx;
            samples[7]   <= probes.trig_mcx;
            samples[8]   <= probes.adc_sample_clk;
         end
         la_pkg::la_group_userio: begin
            samples[7:0] <= probes.userio;
            samples[8]   <= probes.userio_clk;
         end
         la_pkg::la_group_debug: begin
            samples <= probes.debug;
         end
         default: begin
            // Alternating pattern, probe 0 high
            samples <= 9'b1_0101_0101;
         end
      endcase
   end

endmodule

/* verilog/la_regs.sv */
module la_regs #(
   parameter logic [la_pkg::la_depth_w-1:0] depth_init = 16
) (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  la_pkg::la_apb_req_t          apb,
   output logic [la_pkg::la_data_w-1:0] prdata,
   input  logic                         armed,
   input  logic                         capturing,
   output la_pkg::la_config_t           cfg,
   output logic                         arm_req
);

   logic wr_en;
   logic rd_en;
   logic arm;
   logic capturing_q;

   // Zero wait state access phase
   assign wr_en = apb.psel & apb.penable & apb.pwrite;
   assign rd_en = apb.psel & apb.penable & ~apb.pwrite;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         cfg.group      <= la_pkg::la_group_port;
         cfg.trig_sel   <= '0;
         cfg.depth      <= depth_init;
         cfg.downsample <= '0;
         cfg.manual     <= 1'b0;
         arm            <= 1'b0;
         arm_req        <= 1'b0;
         capturing_q    <= 1'b0;
      end else begin
         capturing_q <= capturing;
         arm_req     <= wr_en && (apb.paddr == la_pkg::la_addr_arm) && apb.pwdata[0];

         // ARM drops once the capture has started
         if (capturing & ~capturing_q)
            arm <= 1'b0;

         // A write in the same cycle takes priority over the auto-clear
         if (wr_en) begin
            case (apb.paddr)
               la_pkg::la_addr_group:  cfg.group <= la_pkg::la_group_e'(apb.pwdata[2:0]);
               la_pkg::la_addr_trig:   cfg.trig_sel <= apb.pwdata[5:0];
               la_pkg::la_addr_depth:  cfg.depth <= apb.pwdata[la_pkg::la_depth_w-1:0];
               la_pkg::la_addr_down:   cfg.downsample <= apb.pwdata[la_pkg::la_depth_w-1:0];
               la_pkg::la_addr_manual: cfg.manual <= apb.pwdata[0];
               la_pkg::la_addr_arm:    arm <= apb.pwdata[0];
               default: ;              // STATUS and unmapped are read only
            endcase
         end
      end
   end

   always_comb begin
      prdata = '0;
      if (rd_en) begin
         case (apb.paddr)
            la_pkg::la_addr_group:  prdata[2:0] = cfg.group;
            la_pkg::la_addr_status: prdata[2:0] = {arm, capturing, armed};
            la_pkg::la_addr_trig:   prdata[5:0] = cfg.trig_sel;
            la_pkg::la_addr_depth:  prdata[la_pkg::la_depth_w-1:0] = cfg.depth;
            la_pkg::la_addr_down:   prdata[la_pkg::la_depth_w-1:0] = cfg.downsample;
            la_pkg::la_addr_arm:    prdata[0] = arm;
            la_pkg::la_addr_manual: prdata[0] = cfg.manual;
            default:                prdata = '0;
         endcase
      end
   end

endmodule

/* verilog/la_top.sv */
module la_top #(
   parameter logic [la_pkg::la_depth_w-1:0] depth_init = 16
) (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  la_pkg::la_apb_req_t          apb,
   output logic [la_pkg::la_data_w-1:0] prdata,
   input  la_pkg::la_probes_t           probes,
   output logic                         fifo_wr,
   output la_pkg::la_fifo_word_t        fifo_wr_data,
   output logic                         capture_active
);

   la_pkg::la_config_t            cfg;
   logic                          arm_req;
   logic                          armed;
   logic                          trig_go;
   logic [la_pkg::la_probe_n-1:0] samples;

   la_regs #(.depth_init(depth_init)) la_regs_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .apb          (apb),
      .prdata       (prdata),
      .armed        (armed),
      .capturing    (capture_active),
      .cfg          (cfg),
      .arm_req      (arm_req)
   );

   la_trigger la_trigger_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .probes       (probes),
      .trig_sel     (cfg.trig_sel),
      .manual       (cfg.manual),
      .trig_go      (trig_go)
   );

   la_probe_select la_probe_select_inst (
      .observer_clk (observer_clk),
      .probes       (probes),
      .group        (cfg.group),
      .samples      (samples)
   );

   la_capture la_capture_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .trig_go      (trig_go),
      .arm_req      (arm_req),
      .depth        (cfg.depth),
      .downsample   (cfg.downsample),
      .samples      (samples),
      .armed        (armed),
      .capturing    (capture_active),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data)
   );

endmodule

/* verilog/la_trigger.sv */
module la_trigger (
   input  logic                 observer_clk,
   input  logic                 reset,
   input  la_pkg::la_probes_t   probes,
   input  la_pkg::la_trig_sel_t trig_sel,
   input  logic                 manual,
   output logic                 trig_go
);

   logic       src_sel;
   logic       src_async;
   logic [1:0] sync_q;
   logic       hist_q;

   // Source decode, debug lines take the low codes
   always_comb begin
      if (trig_sel <= 6'd8)
         src_sel = probes.debug[trig_sel[3:0]];
      else if (trig_sel[5])
         src_sel = probes.io[trig_sel[1:0]] ^ trig_sel[3];     // Bit 3 inverts
      else if (trig_sel[3])
         src_sel = probes.userio[trig_sel[2:0]] ^ trig_sel[4]; // Bit 4 inverts
      else
         src_sel = 1'b0;
   end

   assign src_async = src_sel | manual;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q  <= '0;
         hist_q  <= 1'b0;
         trig_go <= 1'b0;
      end else begin
         sync_q  <= {sync_q[0], src_async};   // Two-flop synchronizer
         hist_q  <= sync_q[1];
         trig_go <= sync_q[1] & ~hist_q;      // Rising edge only
      end
   end

endmodule
